// File: Bender.yml
package:
  name: mem_stage

sources:
  - mem_pkg.sv
  - tlb.sv
  - seg_limit_check.sv
  - opswap.sv
  - mem.sv
  - mem_latch.sv
  - mem_stage.sv
  - target: test
    files:
      - mem_stage_tb.sv

// File: mem.sv
`default_nettype none

module mem #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                                  valid_in,
    input  logic [mem_pkg::addr_w-1:0]            eip_in,
    input  logic [mem_pkg::addr_w-1:0]            imm,
    input  logic [mem_pkg::addr_w-1:0]            reg1,
    input  logic [mem_pkg::addr_w-1:0]            reg2,
    input  logic [mem_pkg::addr_w-1:0]            mem_data,
    input  logic [mem_pkg::addr_w-1:0]            mem_addr,
    input  logic [mem_pkg::addr_w-1:0]            mem_addr_end,
    input  logic [mem_pkg::addr_w-1:0]            seg_limit,
    input  logic [mem_pkg::seg_w-1:0]             seg1,
    input  logic [mem_pkg::num_w-1:0]             reg1_num,
    input  logic [mem_pkg::num_w-1:0]             seg1_num,
    input  logic [mem_pkg::sel_w-1:0]             op1_sel,
    input  logic [mem_pkg::sel_w-1:0]             op2_sel,
    input  logic [mem_pkg::dsel_w-1:0]            dest_sel,
    input  logic                                  mem_req,
    input  logic                                  mem_write,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] vp_in,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] pf_in,
    input  logic [TLB_ENTRIES-1:0]                entry_v,
    input  logic [TLB_ENTRIES-1:0]                entry_p,
    input  logic [TLB_ENTRIES-1:0]                entry_rw,
    input  logic                                  ie_in,
    input  logic [mem_pkg::ie_w-1:0]              ie_type_in,
    output logic                                  valid_out,
    output logic [mem_pkg::addr_w-1:0]            eip_out,
    output logic [mem_pkg::addr_w-1:0]            op1_val,
    output logic [mem_pkg::addr_w-1:0]            op2_val,
    output logic [mem_pkg::addr_w-1:0]            dest_addr,
    output logic                                  dest_is_reg,
    output logic                                  dest_is_seg,
    output logic                                  dest_is_mem,
    output logic [mem_pkg::addr_w-1:0]            phys_addr,
    output logic                                  ie_out,
    output logic [mem_pkg::ie_w-1:0]              ie_type_out
);

    logic tlb_miss;
    logic tlb_prot;
    logic seg_prot;

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
        .mem_addr(mem_addr), .mem_req(mem_req), .mem_write(mem_write),
        .vp(vp_in), .pf(pf_in),
        .entry_v(entry_v), .entry_p(entry_p), .entry_rw(entry_rw),
        .phys_addr(phys_addr), .miss(tlb_miss), .prot(tlb_prot)
    );

    seg_limit_check u_seg_limit_check (
        .mem_addr_end(mem_addr_end), .seg_limit(seg_limit),
        .mem_req(mem_req), .seg_prot(seg_prot)
    );

    // memory operands and memory destinations both see the translated address
    opswap u_opswap (
        .reg1(reg1), .reg2(reg2), .seg1(seg1),
        .reg1_num(reg1_num), .seg1_num(seg1_num),
        .mem_data(mem_data), .phys_addr(phys_addr),
        .eip_data(eip_in), .imm(imm),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_sel(dest_sel),
        .op1(op1_val), .op2(op2_val), .dest_addr(dest_addr),
        .dest_is_reg(dest_is_reg), .dest_is_seg(dest_is_seg), .dest_is_mem(dest_is_mem)
    );

    // protection and page fault replace their bits, the upper bits ride along
    always_comb begin
        ie_type_out = ie_type_in;
        ie_type_out[mem_pkg::ie_prot_bit] = seg_prot | tlb_prot;
        ie_type_out[mem_pkg::ie_pf_bit]   = tlb_miss;
    end

    assign ie_out    = ie_in | seg_prot | tlb_prot | tlb_miss;
    assign valid_out = valid_in;
    assign eip_out   = eip_in;

endmodule

`default_nettype wire

// File: mem_latch.sv
`default_nettype none

module mem_latch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clr,
    input  logic                       fwd_stall,
    input  logic                       valid_nxt,
    input  logic [mem_pkg::addr_w-1:0] eip_nxt,
    input  logic [mem_pkg::addr_w-1:0] op1_nxt,
    input  logic [mem_pkg::addr_w-1:0] op2_nxt,
    input  logic [mem_pkg::addr_w-1:0] dest_addr_nxt,
    input  logic                       dest_is_reg_nxt,
    input  logic                       dest_is_seg_nxt,
    input  logic                       dest_is_mem_nxt,
    input  logic [mem_pkg::addr_w-1:0] phys_addr_nxt,
    input  logic                       ie_nxt,
    input  logic [mem_pkg::ie_w-1:0]   ie_type_nxt,
    output logic                       valid_out,
    output logic [mem_pkg::addr_w-1:0] eip_out,
    output logic [mem_pkg::addr_w-1:0] op1_val,
    output logic [mem_pkg::addr_w-1:0] op2_val,
    output logic [mem_pkg::addr_w-1:0] dest_addr,
    output logic                       dest_is_reg,
    output logic                       dest_is_seg,
    output logic                       dest_is_mem,
    output logic [mem_pkg::addr_w-1:0] phys_addr,
    output logic                       ie_out,
    output logic [mem_pkg::ie_w-1:0]   ie_type_out
);

    // control bits, cleared by reset or a flush
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            valid_out <= 1'b0;
            ie_out    <= 1'b0;
        end else if (!fwd_stall) begin
            valid_out <= valid_nxt;
            ie_out    <= ie_nxt;
        end
    end

    // payload only moves when execute can take it
    always_ff @(posedge clk) begin
        if (!fwd_stall) begin
            eip_out     <= eip_nxt;
            op1_val     <= op1_nxt;
            op2_val     <= op2_nxt;
            dest_addr   <= dest_addr_nxt;
            dest_is_reg <= dest_is_reg_nxt;
            dest_is_seg <= dest_is_seg_nxt;
            dest_is_mem <= dest_is_mem_nxt;
            phys_addr   <= phys_addr_nxt;
            ie_type_out <= ie_type_nxt;
        end
    end

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int vpn_w  = 20;
    localparam int off_w  = 12;
    localparam int seg_w  = 16;
    localparam int num_w  = 3;
    localparam int ie_w   = 4;

    // operand source selectors, unused codes read as zero
    localparam int sel_w = 3;
    localparam logic [sel_w-1:0] sel_reg1 = 3'd0;
    localparam logic [sel_w-1:0] sel_reg2 = 3'd1;
    localparam logic [sel_w-1:0] sel_seg1 = 3'd2;
    localparam logic [sel_w-1:0] sel_mem  = 3'd3;
    localparam logic [sel_w-1:0] sel_eip  = 3'd4;
    localparam logic [sel_w-1:0] sel_imm  = 3'd5;

    // destination selectors
    localparam int dsel_w = 2;
    localparam logic [dsel_w-1:0] dsel_none = 2'd0;
    localparam logic [dsel_w-1:0] dsel_reg  = 2'd1;
    localparam logic [dsel_w-1:0] dsel_seg  = 2'd2;
    localparam logic [dsel_w-1:0] dsel_mem  = 2'd3;

    // bit positions inside the exception type field
    localparam int ie_prot_bit = 0;
    localparam int ie_pf_bit   = 1;

endpackage

`default_nettype wire

// File: mem_stage.f
mem_pkg.sv
tlb.sv
seg_limit_check.sv
opswap.sv
mem.sv
mem_latch.sv
mem_stage.sv
mem_stage_tb.sv

// File: mem_stage.sv
`default_nettype none

module mem_stage #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clr,
    input  logic                                  fwd_stall,
    input  logic                                  valid_in,
    input  logic [mem_pkg::addr_w-1:0]            eip_in,
    input  logic [mem_pkg::addr_w-1:0]            imm,
    input  logic [mem_pkg::addr_w-1:0]            reg1,
    input  logic [mem_pkg::addr_w-1:0]            reg2,
    input  logic [mem_pkg::addr_w-1:0]            mem_data,
    input  logic [mem_pkg::addr_w-1:0]            mem_addr,
    input  logic [mem_pkg::addr_w-1:0]            mem_addr_end,
    input  logic [mem_pkg::addr_w-1:0]            seg_limit,
    input  logic [mem_pkg::seg_w-1:0]             seg1,
    input  logic [mem_pkg::num_w-1:0]             reg1_num,
    input  logic [mem_pkg::num_w-1:0]             seg1_num,
    input  logic [mem_pkg::sel_w-1:0]             op1_sel,
    input  logic [mem_pkg::sel_w-1:0]             op2_sel,
    input  logic [mem_pkg::dsel_w-1:0]            dest_sel,
    input  logic                                  mem_req,
    input  logic                                  mem_write,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] vp_in,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] pf_in,
    input  logic [TLB_ENTRIES-1:0]                entry_v,
    input  logic [TLB_ENTRIES-1:0]                entry_p,
    input  logic [TLB_ENTRIES-1:0]                entry_rw,
    input  logic                                  ie_in,
    input  logic [mem_pkg::ie_w-1:0]              ie_type_in,
    output logic                                  valid_out,
    output logic [mem_pkg::addr_w-1:0]            eip_out,
    output logic [mem_pkg::addr_w-1:0]            op1_val,
    output logic [mem_pkg::addr_w-1:0]            op2_val,
    output logic [mem_pkg::addr_w-1:0]            dest_addr,
    output logic                                  dest_is_reg,
    output logic                                  dest_is_seg,
    output logic                                  dest_is_mem,
    output logic [mem_pkg::addr_w-1:0]            phys_addr,
    output logic                                  ie_out,
    output logic [mem_pkg::ie_w-1:0]              ie_type_out
);

    // unregistered stage results
    logic                       nxt_valid;
    logic [mem_pkg::addr_w-1:0] nxt_eip;
    logic [mem_pkg::addr_w-1:0] nxt_op1;
    logic [mem_pkg::addr_w-1:0] nxt_op2;
    logic [mem_pkg::addr_w-1:0] nxt_dest_addr;
    logic                       nxt_dest_is_reg;
    logic                       nxt_dest_is_seg;
    logic                       nxt_dest_is_mem;
    logic [mem_pkg::addr_w-1:0] nxt_phys_addr;
    logic                       nxt_ie;
    logic [mem_pkg::ie_w-1:0]   nxt_ie_type;

    mem #(.TLB_ENTRIES(TLB_ENTRIES)) u_mem (
        .valid_in(valid_in), .eip_in(eip_in), .imm(imm),
        .reg1(reg1), .reg2(reg2), .mem_data(mem_data),
        .mem_addr(mem_addr), .mem_addr_end(mem_addr_end), .seg_limit(seg_limit),
        .seg1(seg1), .reg1_num(reg1_num), .seg1_num(seg1_num),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_sel(dest_sel),
        .mem_req(mem_req), .mem_write(mem_write),
        .vp_in(vp_in), .pf_in(pf_in),
        .entry_v(entry_v), .entry_p(entry_p), .entry_rw(entry_rw),
        .ie_in(ie_in), .ie_type_in(ie_type_in),
        .valid_out(nxt_valid), .eip_out(nxt_eip),
        .op1_val(nxt_op1), .op2_val(nxt_op2), .dest_addr(nxt_dest_addr),
        .dest_is_reg(nxt_dest_is_reg), .dest_is_seg(nxt_dest_is_seg),
        .dest_is_mem(nxt_dest_is_mem), .phys_addr(nxt_phys_addr),
        .ie_out(nxt_ie), .ie_type_out(nxt_ie_type)
    );

    mem_latch u_mem_latch (
        .clk(clk), .reset(reset), .clr(clr), .fwd_stall(fwd_stall),
        .valid_nxt(nxt_valid), .eip_nxt(nxt_eip),
        .op1_nxt(nxt_op1), .op2_nxt(nxt_op2), .dest_addr_nxt(nxt_dest_addr),
        .dest_is_reg_nxt(nxt_dest_is_reg), .dest_is_seg_nxt(nxt_dest_is_seg),
        .dest_is_mem_nxt(nxt_dest_is_mem), .phys_addr_nxt(nxt_phys_addr),
        .ie_nxt(nxt_ie), .ie_type_nxt(nxt_ie_type),
        .valid_out(valid_out), .eip_out(eip_out),
        .op1_val(op1_val), .op2_val(op2_val), .dest_addr(dest_addr),
        .dest_is_reg(dest_is_reg), .dest_is_seg(dest_is_seg),
        .dest_is_mem(dest_is_mem), .phys_addr(phys_addr),
        .ie_out(ie_out), .ie_type_out(ie_type_out)
    );

endmodule

`default_nettype wire

// File: mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;

    localparam int tlb_entries = 8;

    // cycles spent in each test
    localparam int reset_cycles   = 4;
    localparam int n_sel          = 128;
    localparam int n_hit          = 64;
    localparam int n_miss         = 48;
    localparam int n_prot         = 64;
    localparam int n_latch        = 40;
    localparam int drain_cycles   = 2;
    localparam int total_cycles   = reset_cycles + n_sel + n_hit + n_miss + n_prot + n_latch
                                    + 5 * drain_cycles;
    localparam int timeout_cycles = 2 * total_cycles;

    typedef struct packed {
        logic        valid;
        logic [31:0] eip;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] dest_addr;
        logic        dest_is_reg;
        logic        dest_is_seg;
        logic        dest_is_mem;
        logic [31:0] phys;
        logic        ie;
        logic [3:0]  ie_type;
    } result_t;

    logic        clk;
    logic        reset;
    logic        clr;
    logic        fwd_stall;
    logic        valid_in;
    logic [31:0] eip_in;
    logic [31:0] imm;
    logic [31:0] reg1;
    logic [31:0] reg2;
    logic [31:0] mem_data;
    logic [31:0] mem_addr;
    logic [31:0] mem_addr_end;
    logic [31:0] seg_limit;
    logic [15:0] seg1;
    logic [2:0]  reg1_num;
    logic [2:0]  seg1_num;
    logic [mem_pkg::sel_w-1:0]  op1_sel;
    logic [mem_pkg::sel_w-1:0]  op2_sel;
    logic [mem_pkg::dsel_w-1:0] dest_sel;
    logic        mem_req;
    logic        mem_write;
    logic [tlb_entries*20-1:0] vp_in;
    logic [tlb_entries*20-1:0] pf_in;
    logic [tlb_entries-1:0]    entry_v;
    logic [tlb_entries-1:0]    entry_p;
    logic [tlb_entries-1:0]    entry_rw;
    logic        ie_in;
    logic [3:0]  ie_type_in;

    logic        valid_out;
    logic [31:0] eip_out;
    logic [31:0] op1_val;
    logic [31:0] op2_val;
    logic [31:0] dest_addr;
    logic        dest_is_reg;
    logic        dest_is_seg;
    logic        dest_is_mem;
    logic [31:0] phys_addr;
    logic        ie_out;
    logic [3:0]  ie_type_out;

    // TLB contents as the reference sees them
    logic [19:0] tlb_vp [tlb_entries];
    logic [19:0] tlb_pf [tlb_entries];
    int          hit_entries [5] = '{0, 1, 2, 4, 7};

    result_t pend;
    result_t held;
    logic    ctl_only;
    int      checks;
    int      errors;
    int      start_checks;
    int      start_errors;
    int      cycles;
    integer  seed = 32'h8063_44f7;

    mem_stage #(.TLB_ENTRIES(tlb_entries)) u_mem_stage (
        .clk(clk), .reset(reset), .clr(clr), .fwd_stall(fwd_stall),
        .valid_in(valid_in), .eip_in(eip_in), .imm(imm),
        .reg1(reg1), .reg2(reg2), .mem_data(mem_data),
        .mem_addr(mem_addr), .mem_addr_end(mem_addr_end), .seg_limit(seg_limit),
        .seg1(seg1), .reg1_num(reg1_num), .seg1_num(seg1_num),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_sel(dest_sel),
        .mem_req(mem_req), .mem_write(mem_write),
        .vp_in(vp_in), .pf_in(pf_in),
        .entry_v(entry_v), .entry_p(entry_p), .entry_rw(entry_rw),
        .ie_in(ie_in), .ie_type_in(ie_type_in),
        .valid_out(valid_out), .eip_out(eip_out),
        .op1_val(op1_val), .op2_val(op2_val), .dest_addr(dest_addr),
        .dest_is_reg(dest_is_reg), .dest_is_seg(dest_is_seg),
        .dest_is_mem(dest_is_mem), .phys_addr(phys_addr),
        .ie_out(ie_out), .ie_type_out(ie_type_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] pick_operand(input logic [2:0] sel);
        case (sel)
            mem_pkg::sel_reg1: pick_operand = reg1;
            mem_pkg::sel_reg2: pick_operand = reg2;
            mem_pkg::sel_seg1: pick_operand = {16'd0, seg1};
            mem_pkg::sel_mem:  pick_operand = mem_data;
            mem_pkg::sel_eip:  pick_operand = eip_in;
            mem_pkg::sel_imm:  pick_operand = imm;
            default:           pick_operand = 32'd0;
        endcase
    endfunction

    // expected stage result for the inputs currently applied
    function automatic result_t reference();
        result_t     r;
        logic        hit;
        logic        hit_rw;
        logic [19:0] frame;
        logic        seg_prot;
        logic        tlb_miss;
        logic        tlb_prot;
        hit    = 1'b0;
        hit_rw = 1'b0;
        frame  = 20'd0;
        // first valid and present match wins
        for (int i = 0; i < tlb_entries; i++) begin
            if (!hit && entry_v[i] && entry_p[i] && tlb_vp[i] == mem_addr[31:12]) begin
                hit    = 1'b1;
                hit_rw = entry_rw[i];
                frame  = tlb_pf[i];
            end
        end
        r           = '0;
        r.phys      = hit ? {frame, mem_addr[11:0]} : mem_addr;
        tlb_miss    = mem_req && !hit;
        tlb_prot    = mem_req && hit && mem_write && !hit_rw;
        seg_prot    = mem_req && (mem_addr_end >= seg_limit);
        r.valid     = valid_in;
        r.eip       = eip_in;
        r.op1       = pick_operand(op1_sel);
        r.op2       = pick_operand(op2_sel);
        case (dest_sel)
            mem_pkg::dsel_reg: begin
                r.dest_addr   = {29'd0, reg1_num};
                r.dest_is_reg = 1'b1;
            end
            mem_pkg::dsel_seg: begin
                r.dest_addr   = {29'd0, seg1_num};
                r.dest_is_seg = 1'b1;
            end
            mem_pkg::dsel_mem: begin
                r.dest_addr   = r.phys;
                r.dest_is_mem = 1'b1;
            end
            default: r.dest_addr = 32'd0;
        endcase
        r.ie_type = {ie_type_in[3:2], tlb_miss, seg_prot | tlb_prot};
        r.ie      = ie_in | seg_prot | tlb_prot | tlb_miss;
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // the latch model updates at the rising edge and outputs are checked at the falling edge
    initial begin
        held     = '0;
        ctl_only = 1'b1;
        forever begin
            @(posedge clk);
            if (!fwd_stall) begin
                held     = pend;
                ctl_only = 1'b0;
            end
            if (reset || clr) begin
                held.valid = 1'b0;
                held.ie    = 1'b0;
                // payload after a flush is not defined
                ctl_only   = 1'b1;
            end
            @(negedge clk);
            check("valid_out", held.valid, valid_out);
            check("ie_out", held.ie, ie_out);
            if (!ctl_only) begin
                check("eip_out", held.eip, eip_out);
                check("op1_val", held.op1, op1_val);
                check("op2_val", held.op2, op2_val);
                check("dest_addr", held.dest_addr, dest_addr);
                check("dest_is_reg", held.dest_is_reg, dest_is_reg);
                check("dest_is_seg", held.dest_is_seg, dest_is_seg);
                check("dest_is_mem", held.dest_is_mem, dest_is_mem);
                check("phys_addr", held.phys, phys_addr);
                check("ie_type_out", held.ie_type, ie_type_out);
            end
        end
    end

    always @(posedge clk)
        cycles++;

    initial begin
        wait (cycles >= timeout_cycles);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic randomize_fields();
        reg1       = $random(seed);
        reg2       = $random(seed);
        imm        = $random(seed);
        eip_in     = $random(seed);
        mem_data   = $random(seed);
        seg1       = $random(seed);
        reg1_num   = $random(seed);
        seg1_num   = $random(seed);
        valid_in   = $random(seed);
        ie_in      = $random(seed);
        ie_type_in = $random(seed);
        mem_addr   = $random(seed);
        mem_addr_end = mem_addr + 32'd3;
        seg_limit  = 32'hffff_fff0;
    endtask

    task automatic start_test();
        start_checks = checks;
        start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        repeat (drain_cycles) @(posedge clk);
        $display("%s: %0d checks, %0d errors", name, checks - start_checks,
                 errors - start_errors);
    endtask

    task automatic select_test();
        start_test();
        for (int i = 0; i < n_sel; i++) begin
            @(negedge clk);
            randomize_fields();
            op1_sel  = i[2:0];
            op2_sel  = i[5:3];
            dest_sel = i[6:5];
            mem_req  = 1'b0;
            pend     = reference();
        end
        finish_test("operand and destination select");
    endtask

    task automatic tlb_hit_test();
        int e;
        start_test();
        for (int i = 0; i < n_hit; i++) begin
            @(negedge clk);
            randomize_fields();
            e         = hit_entries[i % 5];
            mem_addr  = {tlb_vp[e], mem_addr[11:0]};
            mem_addr_end = mem_addr + 32'd3;
            mem_req   = 1'b1;
            mem_write = 1'b0;
            ie_in     = 1'b0;
            op1_sel   = mem_pkg::sel_mem;
            op2_sel   = $random(seed);
            dest_sel  = mem_pkg::dsel_mem;
            pend      = reference();
        end
        finish_test("tlb hit");
    endtask

    task automatic tlb_miss_test();
        start_test();
        for (int i = 0; i < n_miss; i++) begin
            @(negedge clk);
            randomize_fields();
            case (i % 3)
                0: mem_addr[31:12] = tlb_vp[3];
                1: mem_addr[31:12] = tlb_vp[6];
                default: mem_addr[31] = 1'b1;
            endcase
            mem_addr_end = mem_addr + 32'd3;
            mem_req   = 1'b1;
            mem_write = $random(seed);
            dest_sel  = mem_pkg::dsel_mem;
            pend      = reference();
        end
        finish_test("tlb miss");
    endtask

    task automatic protection_test();
        start_test();
        for (int i = 0; i < n_prot; i++) begin
            @(negedge clk);
            randomize_fields();
            seg_limit = 32'h0010_0000 + mem_data[15:0];
            mem_req   = 1'b1;
            ie_in     = 1'b0;
            dest_sel  = mem_pkg::dsel_mem;
            case (i % 4)
                // write to the read-only page
                0: begin
                    mem_addr  = {tlb_vp[2], mem_addr[11:0]};
                    mem_addr_end = mem_addr + 32'd3;
                    mem_write = 1'b1;
                end
                // end address on or past the limit
                1: begin
                    mem_addr  = {tlb_vp[1], mem_addr[11:0]};
                    mem_addr_end = (i % 8 == 1) ? seg_limit : seg_limit + imm[7:0] + 32'd1;
                    mem_write = 1'b0;
                end
                2: begin
                    mem_addr  = {tlb_vp[2], mem_addr[11:0]};
                    mem_addr_end = mem_addr + 32'd3;
                    mem_write = 1'b0;
                end
                default: begin
                    mem_addr  = {tlb_vp[0], mem_addr[11:0]};
                    mem_addr_end = seg_limit - 32'd1;
                    mem_write = 1'b1;
                end
            endcase
            pend = reference();
        end
        finish_test("protection");
    endtask

    // a clr pulse followed by a stall window with moving inputs and a reset pulse
    task automatic latch_test();
        start_test();
        for (int i = 0; i < n_latch; i++) begin
            @(negedge clk);
            randomize_fields();
            mem_req   = $random(seed);
            mem_write = $random(seed);
            op1_sel   = $random(seed);
            op2_sel   = $random(seed);
            dest_sel  = $random(seed);
            valid_in  = 1'b1;
            clr       = (i == 8);
            fwd_stall = (i >= 16 && i < 24);
            reset     = (i == 32 || i == 33);
            if (clr || reset)
                ie_in = 1'b1;
            pend = reference();
        end
        finish_test("latch control");
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        reset     = 1'b1;
        clr       = 1'b0;
        fwd_stall = 1'b0;
        mem_req   = 1'b0;
        mem_write = 1'b0;
        op1_sel   = '0;
        op2_sel   = '0;
        dest_sel  = '0;
        randomize_fields();
        // entry 5 repeats the page of entry 1 with another frame
        tlb_vp = '{20'h00010, 20'h00020, 20'h00030, 20'h00040,
                   20'h00050, 20'h00020, 20'h00060, 20'h00070};
        tlb_pf = '{20'h80010, 20'h80020, 20'h80030, 20'h80040,
                   20'h80050, 20'h90020, 20'h80060, 20'h80070};
        entry_v  = 8'b1011_1111;
        entry_p  = 8'b1111_0111;
        entry_rw = 8'b1111_1011;
        for (int i = 0; i < tlb_entries; i++) begin
            vp_in[i*20 +: 20] = tlb_vp[i];
            pf_in[i*20 +: 20] = tlb_pf[i];
        end
        pend = reference();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        select_test();
        tlb_hit_test();
        tlb_miss_test();
        protection_test();
        latch_test();
        if (checks == 0) begin
            errors++;
            $display("no output was ever compared");
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: opswap.sv
`default_nettype none

module opswap (
    input  logic [mem_pkg::addr_w-1:0] reg1,
    input  logic [mem_pkg::addr_w-1:0] reg2,
    input  logic [mem_pkg::seg_w-1:0]  seg1,
    input  logic [mem_pkg::num_w-1:0]  reg1_num,
    input  logic [mem_pkg::num_w-1:0]  seg1_num,
    input  logic [mem_pkg::addr_w-1:0] mem_data,
    input  logic [mem_pkg::addr_w-1:0] phys_addr,
    input  logic [mem_pkg::addr_w-1:0] eip_data,
    input  logic [mem_pkg::addr_w-1:0] imm,
    input  logic [mem_pkg::sel_w-1:0]  op1_sel,
    input  logic [mem_pkg::sel_w-1:0]  op2_sel,
    input  logic [mem_pkg::dsel_w-1:0] dest_sel,
    output logic [mem_pkg::addr_w-1:0] op1,
    output logic [mem_pkg::addr_w-1:0] op2,
    output logic [mem_pkg::addr_w-1:0] dest_addr,
    output logic                       dest_is_reg,
    output logic                       dest_is_seg,
    output logic                       dest_is_mem
);

    localparam int num_src = 1 << mem_pkg::sel_w;

    // one table of sources shared by both operand ports
    logic [mem_pkg::addr_w-1:0] src [num_src];

    always_comb begin
        src = '{default: '0};
        src[mem_pkg::sel_reg1] = reg1;
        src[mem_pkg::sel_reg2] = reg2;
        src[mem_pkg::sel_seg1] = {{(mem_pkg::addr_w - mem_pkg::seg_w){1'b0}}, seg1};
        src[mem_pkg::sel_mem]  = mem_data;
        src[mem_pkg::sel_eip]  = eip_data;
        src[mem_pkg::sel_imm]  = imm;
    end

    assign op1 = src[op1_sel];
    assign op2 = src[op2_sel];

    // destination is a register number, a segment number or a memory address
    always_comb begin
        dest_addr   = '0;
        dest_is_reg = 1'b0;
        dest_is_seg = 1'b0;
        dest_is_mem = 1'b0;
        case (dest_sel)
            mem_pkg::dsel_reg: begin
                dest_addr   = {{(mem_pkg::addr_w - mem_pkg::num_w){1'b0}}, reg1_num};
                dest_is_reg = 1'b1;
            end
            mem_pkg::dsel_seg: begin
                dest_addr   = {{(mem_pkg::addr_w - mem_pkg::num_w){1'b0}}, seg1_num};
                dest_is_seg = 1'b1;
            end
            mem_pkg::dsel_mem: begin
                dest_addr   = phys_addr;
                dest_is_mem = 1'b1;
            end
            default: begin
                // dsel_none leaves everything low
                dest_addr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: seg_limit_check.sv
`default_nettype none

module seg_limit_check (
    input  logic [mem_pkg::addr_w-1:0] mem_addr_end,
    input  logic [mem_pkg::addr_w-1:0] seg_limit,
    input  logic                       mem_req,
    output logic                       seg_prot
);

    logic end_gt_limit;
    logic end_eq_limit;
    logic over_limit;

    // unsigned compare of the last byte touched against the limit
    assign end_gt_limit = mem_addr_end > seg_limit;
    assign end_eq_limit = mem_addr_end == seg_limit;

    // touching the limit byte itself is already out of range
    assign over_limit = end_gt_limit | end_eq_limit;

    // no access, no fault
    assign seg_prot = mem_req & over_limit;

endmodule

`default_nettype wire

// File: tlb.sv
`default_nettype none

module tlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic [mem_pkg::addr_w-1:0]            mem_addr,
    input  logic                                  mem_req,
    input  logic                                  mem_write,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] vp,
    input  logic [TLB_ENTRIES*mem_pkg::vpn_w-1:0] pf,
    input  logic [TLB_ENTRIES-1:0]                entry_v,
    input  logic [TLB_ENTRIES-1:0]                entry_p,
    input  logic [TLB_ENTRIES-1:0]                entry_rw,
    output logic [mem_pkg::addr_w-1:0]            phys_addr,
    output logic                                  miss,
    output logic                                  prot
);

    logic [mem_pkg::vpn_w-1:0] vpn;
    logic [mem_pkg::vpn_w-1:0] frame;
    logic                      hit;
    logic                      hit_rw;

    assign vpn = mem_addr[mem_pkg::addr_w-1:mem_pkg::off_w];

    // scan from the top so the lowest matching entry is the last to write
    always_comb begin
        hit    = 1'b0;
        hit_rw = 1'b0;
        frame  = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_v[i] && entry_p[i] &&
                vp[i*mem_pkg::vpn_w +: mem_pkg::vpn_w] == vpn) begin
                hit    = 1'b1;
                hit_rw = entry_rw[i];
                frame  = pf[i*mem_pkg::vpn_w +: mem_pkg::vpn_w];
            end
        end
    end

    // untranslated address passes through on a miss
    assign phys_addr = hit ? {frame, mem_addr[mem_pkg::off_w-1:0]} : mem_addr;

    // faults only count for a real request
    assign miss = mem_req & ~hit;

    // write to a read-only page
    assign prot = mem_req & hit & mem_write & ~hit_rw;

endmodule

`default_nettype wire
